//--- Makefile
TOP = tb_pcie_queue

.PHONY: sim clean

# the log decides pass or fail
sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- list.f
+incdir+source
source/qtable_pkg.sv
source/qtable_port_if.sv
source/qtable_bram.sv
source/host_port_arbiter.sv
source/queue_context_loader.sv
source/pcie_queue_top.sv
sim/tb_pcie_queue.sv

//--- sim/tb_pcie_queue.sv
`timescale 1ns/1ns
`default_nettype none
`include "qtable_config.svh"

module tb_pcie_queue;
    import qtable_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic       pcie_clk;
    logic       pcie_reset_n;
    host_addr_t pcie_address_0;
    logic       pcie_write_0;
    logic       pcie_read_0;
    host_data_t pcie_writedata_0;
    host_be_t   pcie_byteenable_0;
    host_data_t pcie_readdata_0;
    logic       pcie_readdatavalid_0;
    logic       dma_start;
    queue_idx_t dma_queue;
    logic       dma_done;
    reg_word_t  new_tail;
    logic       f2c_queue_ready;
    reg_word_t  f2c_head;
    reg_word_t  f2c_tail;
    kmem_addr_t f2c_kmem_addr;

    // reference model of the table and the live context
    reg_word_t  model_tail [`QT_NB_QUEUES];
    reg_word_t  model_head [`QT_NB_QUEUES];
    reg_word_t  model_lo [`QT_NB_QUEUES];
    reg_word_t  model_hi [`QT_NB_QUEUES];
    reg_word_t  model_c2f_tail;
    kmem_addr_t model_c2f_kmem;
    reg_word_t  exp_head;
    reg_word_t  exp_tail;
    kmem_addr_t exp_kmem;
    queue_idx_t active_q;
    logic       active_valid;
    host_data_t exp_line;
    logic       read_outstanding;
    int         errors;
    int         timeouts;

    pcie_queue_top uut (
        .pcie_clk             (pcie_clk),
        .pcie_reset_n         (pcie_reset_n),
        .pcie_address_0       (pcie_address_0),
        .pcie_write_0         (pcie_write_0),
        .pcie_read_0          (pcie_read_0),
        .pcie_writedata_0     (pcie_writedata_0),
        .pcie_byteenable_0    (pcie_byteenable_0),
        .pcie_readdata_0      (pcie_readdata_0),
        .pcie_readdatavalid_0 (pcie_readdatavalid_0),
        .dma_start            (dma_start),
        .dma_queue            (dma_queue),
        .dma_done             (dma_done),
        .new_tail             (new_tail),
        .f2c_queue_ready      (f2c_queue_ready),
        .f2c_head             (f2c_head),
        .f2c_tail             (f2c_tail),
        .f2c_kmem_addr        (f2c_kmem_addr)
    );

    initial begin
        pcie_clk = 1'b0;
        forever #50 pcie_clk = ~pcie_clk;
    end

    // one pulse per outstanding read, carrying the model's page
    valid_needs_read: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_readdatavalid_0 |-> read_outstanding)
        else begin
            errors++;
            $display("read data valid pulse without an outstanding read");
        end
    readdata_matches: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_readdatavalid_0 |-> pcie_readdata_0 == exp_line)
        else begin
            errors++;
            $display("Error: pcie_readdata_0 is %h, expected %h", pcie_readdata_0, exp_line);
        end
    ready_after_start: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        dma_start |-> ##4 f2c_queue_ready)
        else begin
            errors++;
            $display("f2c_queue_ready did not follow dma_start after 4 cycles");
        end
    ready_not_early: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        f2c_queue_ready |-> $past(dma_start, 4))
        else begin
            errors++;
            $display("f2c_queue_ready without a dma_start 4 cycles earlier");
        end
    ready_head: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        f2c_queue_ready |-> f2c_head == exp_head)
        else begin
            errors++;
            $display("Error: f2c_head is %h, expected %h", f2c_head, exp_head);
        end
    ready_tail: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        f2c_queue_ready |-> f2c_tail == exp_tail)
        else begin
            errors++;
            $display("Error: f2c_tail is %h, expected %h", f2c_tail, exp_tail);
        end
    ready_kmem: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        f2c_queue_ready |-> f2c_kmem_addr == exp_kmem)
        else begin
            errors++;
            $display("Error: f2c_kmem_addr is %h, expected %h", f2c_kmem_addr, exp_kmem);
        end
    done_tail: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        dma_done |=> f2c_tail == $past(new_tail))
        else begin
            errors++;
            $display("Error: f2c_tail is %h, expected %h", f2c_tail, new_tail);
        end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Error: %s is %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    function automatic host_data_t random_line();
        host_data_t line;
        for (int i = 0; i < 16; i++) begin
            line[i*32 +: 32] = $urandom;
        end
        return line;
    endfunction

    function automatic host_be_t enables_for(input logic [7:0] words);
        host_be_t be;
        be = '0;
        for (int i = 0; i < 8; i++) begin
            if (words[i]) begin
                be[i*`QT_REG_SIZE +: `QT_REG_SIZE] = '1;
            end
        end
        return be;
    endfunction

    // readback line built from the model, word 5 and upper half stay zero
    function automatic host_data_t expected_line(input queue_idx_t q);
        host_data_t line;
        line = '0;
        line[`QT_WORD_TAIL*32 +: 32] = model_tail[q];
        line[`QT_WORD_HEAD*32 +: 32] = model_head[q];
        line[`QT_WORD_L_ADDR*32 +: 32] = model_lo[q];
        line[`QT_WORD_H_ADDR*32 +: 32] = model_hi[q];
        line[`QT_WORD_C2F_TAIL*32 +: 32] = model_c2f_tail;
        line[`QT_WORD_C2F_KMEM_LO*32 +: 32] = model_c2f_kmem[31:0];
        line[`QT_WORD_C2F_KMEM_HI*32 +: 32] = model_c2f_kmem[63:32];
        return line;
    endfunction

    task automatic check_context();
        check_value("f2c_head", 64'(f2c_head), 64'(exp_head));
        check_value("f2c_tail", 64'(f2c_tail), 64'(exp_tail));
        check_value("f2c_kmem_addr", f2c_kmem_addr, exp_kmem);
    endtask

    task automatic apply_reset();
        pcie_reset_n = 1'b0;
        for (int i = 0; i < 4; i++) begin
            @(negedge pcie_clk);
            check_value("pcie_readdatavalid_0", 64'(pcie_readdatavalid_0), 64'h0);
            check_value("f2c_queue_ready", 64'(f2c_queue_ready), 64'h0);
            check_context();
        end
        pcie_reset_n = 1'b1;
        @(negedge pcie_clk);
        check_value("pcie_readdatavalid_0", 64'(pcie_readdatavalid_0), 64'h0);
        check_value("f2c_queue_ready", 64'(f2c_queue_ready), 64'h0);
        check_context();
    endtask

    task automatic host_write(input queue_idx_t q, input host_data_t data, input host_be_t be);
        logic [7:0] full;
        reg_word_t  w [8];
        for (int i = 0; i < 8; i++) begin
            w[i] = data[i*32 +: 32];
            full[i] = &be[i*`QT_REG_SIZE +: `QT_REG_SIZE];
        end
        pcie_address_0 = '0;
        pcie_address_0[`QT_PAGE_LSB +: `QT_APP_IDX_WIDTH] = q;
        pcie_writedata_0 = data;
        pcie_byteenable_0 = be;
        pcie_write_0 = 1'b1;
        // the tail word only reaches the live context, never the table
        if (full[`QT_WORD_HEAD]) model_head[q] = w[`QT_WORD_HEAD];
        if (full[`QT_WORD_L_ADDR]) model_lo[q] = w[`QT_WORD_L_ADDR];
        if (full[`QT_WORD_H_ADDR]) model_hi[q] = w[`QT_WORD_H_ADDR];
        if (full[`QT_WORD_C2F_TAIL]) model_c2f_tail = w[`QT_WORD_C2F_TAIL];
        if (full[`QT_WORD_C2F_KMEM_LO]) model_c2f_kmem[31:0] = w[`QT_WORD_C2F_KMEM_LO];
        if (full[`QT_WORD_C2F_KMEM_HI]) model_c2f_kmem[63:32] = w[`QT_WORD_C2F_KMEM_HI];
        if (active_valid && q == active_q) begin
            if (full[`QT_WORD_TAIL]) exp_tail = w[`QT_WORD_TAIL];
            if (full[`QT_WORD_HEAD]) exp_head = w[`QT_WORD_HEAD];
            if (full[`QT_WORD_L_ADDR]) exp_kmem[31:0] = w[`QT_WORD_L_ADDR];
            if (full[`QT_WORD_H_ADDR]) exp_kmem[63:32] = w[`QT_WORD_H_ADDR];
        end
        @(negedge pcie_clk);
        pcie_write_0 = 1'b0;
        pcie_byteenable_0 = '0;
    endtask

    task automatic read_page(input queue_idx_t q);
        int cycles;
        exp_line = expected_line(q);
        pcie_address_0 = '0;
        pcie_address_0[`QT_PAGE_LSB +: `QT_APP_IDX_WIDTH] = q;
        pcie_read_0 = 1'b1;
        read_outstanding = 1'b1;
        @(negedge pcie_clk);
        pcie_read_0 = 1'b0;
        cycles = 0;
        while (!pcie_readdatavalid_0 && cycles < WAIT_LIMIT) begin
            @(negedge pcie_clk);
            cycles++;
        end
        if (!pcie_readdatavalid_0) begin
            timeouts++;
            $display("timeout: no read data valid for page %0d", q);
            finish_run();
        end else begin
            // the valid pulse lasts one cycle
            @(negedge pcie_clk);
            check_value("pcie_readdatavalid_0", 64'(pcie_readdatavalid_0), 64'h0);
            read_outstanding = 1'b0;
        end
    endtask

    task automatic start_dma(input queue_idx_t q);
        int cycles;
        exp_head = model_head[q];
        exp_tail = model_tail[q];
        exp_kmem = {model_hi[q], model_lo[q]};
        active_q = q;
        active_valid = 1'b1;
        dma_queue = q;
        dma_start = 1'b1;
        @(negedge pcie_clk);
        dma_start = 1'b0;
        cycles = 0;
        while (!f2c_queue_ready && cycles < WAIT_LIMIT) begin
            @(negedge pcie_clk);
            cycles++;
        end
        if (!f2c_queue_ready) begin
            timeouts++;
            $display("timeout: f2c_queue_ready never rose for queue %0d", q);
            finish_run();
        end else begin
            // ready checks sample the context at the end of the pulse
            @(negedge pcie_clk);
        end
    endtask

    task automatic finish_dma(input reg_word_t tail);
        new_tail = tail;
        dma_done = 1'b1;
        model_tail[active_q] = tail;
        exp_tail = tail;
        @(negedge pcie_clk);
        dma_done = 1'b0;
        @(negedge pcie_clk);
    endtask

    initial begin
        host_be_t be;
        void'($urandom(32'haf8d));
        errors = 0;
        timeouts = 0;
        pcie_reset_n = 1'b0;
        pcie_address_0 = '0;
        pcie_write_0 = 1'b0;
        pcie_read_0 = 1'b0;
        pcie_writedata_0 = '0;
        pcie_byteenable_0 = '0;
        dma_start = 1'b0;
        dma_queue = '0;
        dma_done = 1'b0;
        new_tail = '0;
        for (int q = 0; q < `QT_NB_QUEUES; q++) begin
            model_tail[q] = '0;
            model_head[q] = '0;
            model_lo[q] = '0;
            model_hi[q] = '0;
        end
        model_c2f_tail = '0;
        model_c2f_kmem = '0;
        exp_head = '0;
        exp_tail = '0;
        exp_kmem = '0;
        active_q = '0;
        active_valid = 1'b0;
        exp_line = '0;
        read_outstanding = 1'b0;
        apply_reset();

        // head, address and cpu to fpga words on every page
        for (int q = 0; q < `QT_NB_QUEUES; q++) begin
            host_write(queue_idx_t'(q), random_line(), enables_for(8'b1101_1110));
        end
        for (int q = 0; q < `QT_NB_QUEUES; q++) begin
            read_page(queue_idx_t'(q));
        end

        // groups with a missing byte leave their words alone
        be = '0;
        be[`QT_WORD_HEAD*`QT_REG_SIZE +: `QT_REG_SIZE] = 4'b0111;
        be[`QT_WORD_L_ADDR*`QT_REG_SIZE +: `QT_REG_SIZE] = 4'b1110;
        be[`QT_WORD_C2F_KMEM_HI*`QT_REG_SIZE +: `QT_REG_SIZE] = 4'b1011;
        host_write(2'd1, random_line(), be);
        read_page(2'd1);

        // live update of the active queue while the engine runs
        start_dma(2'd2);
        host_write(2'd2, random_line(), enables_for(8'b0000_1111));
        @(negedge pcie_clk);
        check_context();
        finish_dma($urandom);
        read_page(2'd2);

        start_dma(2'd1);
        finish_dma($urandom);
        read_page(2'd1);
        start_dma(2'd2);
        finish_dma($urandom);
        read_page(2'd2);
        start_dma(2'd0);
        finish_dma($urandom);
        read_page(2'd0);
        finish_run();
    end
endmodule

`default_nettype wire

//--- source/host_port_arbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "qtable_config.svh"

module host_port_arbiter (
    input  wire                          pcie_clk,
    input  wire                          pcie_reset_n,
    input  wire qtable_pkg::host_addr_t  pcie_address_0,
    input  wire                          pcie_write_0,
    input  wire                          pcie_read_0,
    input  wire qtable_pkg::host_data_t  pcie_writedata_0,
    input  wire qtable_pkg::host_be_t    pcie_byteenable_0,
    output qtable_pkg::host_data_t       pcie_readdata_0,
    output logic                         pcie_readdatavalid_0,
    output qtable_pkg::field_mask_t      host_update_mask,
    output qtable_pkg::queue_idx_t       host_update_queue,
    output qtable_pkg::field_words_t     host_update_words,
    qtable_port_if.requester             tails_b,
    qtable_port_if.requester             heads_b,
    qtable_port_if.requester             l_addrs_b,
    qtable_port_if.requester             h_addrs_b
);
    import qtable_pkg::*;

    queue_idx_t page_idx;
    logic [7:0] word_full;
    queue_idx_t port_addr;
    logic       rd_pending;
    queue_idx_t rd_page;
    logic       rd_en_q;
    logic [`QT_BRAM_READ_LATENCY-1:0] rd_vld_q;
    reg_word_t  c2f_tail;
    kmem_addr_t c2f_kmem_addr;

    assign page_idx = pcie_address_0[`QT_PAGE_LSB +: `QT_APP_IDX_WIDTH];

    // a word counts only when all four of its bytes are enabled
    for (genvar i = 0; i < 8; i++) begin : g_full
        assign word_full[i] = &pcie_byteenable_0[i*`QT_REG_SIZE +: `QT_REG_SIZE];
    end

    // writes win port b, a pending read waits for a write-free cycle
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            host_update_mask <= '0;
            rd_pending <= 1'b0;
            rd_en_q <= 1'b0;
            rd_vld_q <= '0;
            c2f_tail <= '0;
            c2f_kmem_addr <= '0;
        end else begin
            host_update_mask <= '0;
            rd_en_q <= 1'b0;
            rd_vld_q <= {rd_vld_q[`QT_BRAM_READ_LATENCY-2:0], rd_en_q};
            if (pcie_write_0) begin
                host_update_mask[TAILS] <= word_full[`QT_WORD_TAIL];
                host_update_mask[HEADS] <= word_full[`QT_WORD_HEAD];
                host_update_mask[L_ADDRS] <= word_full[`QT_WORD_L_ADDR];
                host_update_mask[H_ADDRS] <= word_full[`QT_WORD_H_ADDR];
                if (word_full[`QT_WORD_C2F_TAIL]) begin
                    c2f_tail <= pcie_writedata_0[`QT_WORD_C2F_TAIL*32 +: 32];
                end
                if (word_full[`QT_WORD_C2F_KMEM_LO]) begin
                    c2f_kmem_addr[31:0] <= pcie_writedata_0[`QT_WORD_C2F_KMEM_LO*32 +: 32];
                end
                if (word_full[`QT_WORD_C2F_KMEM_HI]) begin
                    c2f_kmem_addr[63:32] <= pcie_writedata_0[`QT_WORD_C2F_KMEM_HI*32 +: 32];
                end
            end else if (rd_pending) begin
                rd_en_q <= 1'b1;
                rd_pending <= 1'b0;
            end
            if (pcie_read_0) begin
                rd_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_write_0) begin
            host_update_queue <= page_idx;
            host_update_words <= pcie_writedata_0[$bits(field_words_t)-1:0];
        end
        if (pcie_read_0) begin
            rd_page <= page_idx;
        end
    end

    assign port_addr = rd_en_q ? rd_page : host_update_queue;

    assign tails_b.addr = port_addr;
    assign heads_b.addr = port_addr;
    assign l_addrs_b.addr = port_addr;
    assign h_addrs_b.addr = port_addr;

    // tails belong to the loader
    assign tails_b.wr_en = 1'b0;
    assign tails_b.wr_data = '0;
    assign heads_b.wr_en = host_update_mask[HEADS];
    assign heads_b.wr_data = host_update_words[32*HEADS +: 32];
    assign l_addrs_b.wr_en = host_update_mask[L_ADDRS];
    assign l_addrs_b.wr_data = host_update_words[32*L_ADDRS +: 32];
    assign h_addrs_b.wr_en = host_update_mask[H_ADDRS];
    assign h_addrs_b.wr_data = host_update_words[32*H_ADDRS +: 32];

    assign tails_b.rd_en = rd_en_q;
    assign heads_b.rd_en = rd_en_q;
    assign l_addrs_b.rd_en = rd_en_q;
    assign h_addrs_b.rd_en = rd_en_q;

    // response line, unused words stay zero
    always_comb begin
        pcie_readdata_0 = '0;
        pcie_readdata_0[`QT_WORD_TAIL*32 +: 32] = tails_b.rd_data;
        pcie_readdata_0[`QT_WORD_HEAD*32 +: 32] = heads_b.rd_data;
        pcie_readdata_0[`QT_WORD_L_ADDR*32 +: 32] = l_addrs_b.rd_data;
        pcie_readdata_0[`QT_WORD_H_ADDR*32 +: 32] = h_addrs_b.rd_data;
        pcie_readdata_0[`QT_WORD_C2F_TAIL*32 +: 32] = c2f_tail;
        pcie_readdata_0[`QT_WORD_C2F_KMEM_LO*32 +: 32] = c2f_kmem_addr[31:0];
        pcie_readdata_0[`QT_WORD_C2F_KMEM_HI*32 +: 32] = c2f_kmem_addr[63:32];
    end

    assign pcie_readdatavalid_0 = rd_vld_q[`QT_BRAM_READ_LATENCY-1];

    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        rd_en_q |-> !(heads_b.wr_en || l_addrs_b.wr_en || h_addrs_b.wr_en))
        else $error("host_port_arbiter: port b read and write in one cycle");

    // host keeps at most one read outstanding
    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        pcie_read_0 |-> !rd_pending)
        else $error("host_port_arbiter: read while another is pending");
endmodule

`default_nettype wire

//--- source/pcie_queue_top.sv
`timescale 1ns/1ns
`default_nettype none

module pcie_queue_top (
    input  wire                          pcie_clk,
    input  wire                          pcie_reset_n,
    input  wire qtable_pkg::host_addr_t  pcie_address_0,
    input  wire                          pcie_write_0,
    input  wire                          pcie_read_0,
    input  wire qtable_pkg::host_data_t  pcie_writedata_0,
    input  wire qtable_pkg::host_be_t    pcie_byteenable_0,
    output qtable_pkg::host_data_t       pcie_readdata_0,
    output logic                         pcie_readdatavalid_0,
    input  wire                          dma_start,
    input  wire qtable_pkg::queue_idx_t  dma_queue,
    input  wire                          dma_done,
    input  wire qtable_pkg::reg_word_t   new_tail,
    output logic                         f2c_queue_ready,
    output qtable_pkg::reg_word_t        f2c_head,
    output qtable_pkg::reg_word_t        f2c_tail,
    output qtable_pkg::kmem_addr_t       f2c_kmem_addr
);
    import qtable_pkg::*;

    field_mask_t  host_update_mask;
    queue_idx_t   host_update_queue;
    field_words_t host_update_words;

    // port a serves the loader, port b the host
    qtable_port_if tails_a ();
    qtable_port_if heads_a ();
    qtable_port_if l_addrs_a ();
    qtable_port_if h_addrs_a ();
    qtable_port_if tails_b ();
    qtable_port_if heads_b ();
    qtable_port_if l_addrs_b ();
    qtable_port_if h_addrs_b ();

    host_port_arbiter u_arbiter (
        .pcie_clk             (pcie_clk),
        .pcie_reset_n         (pcie_reset_n),
        .pcie_address_0       (pcie_address_0),
        .pcie_write_0         (pcie_write_0),
        .pcie_read_0          (pcie_read_0),
        .pcie_writedata_0     (pcie_writedata_0),
        .pcie_byteenable_0    (pcie_byteenable_0),
        .pcie_readdata_0      (pcie_readdata_0),
        .pcie_readdatavalid_0 (pcie_readdatavalid_0),
        .host_update_mask     (host_update_mask),
        .host_update_queue    (host_update_queue),
        .host_update_words    (host_update_words),
        .tails_b              (tails_b),
        .heads_b              (heads_b),
        .l_addrs_b            (l_addrs_b),
        .h_addrs_b            (h_addrs_b)
    );

    queue_context_loader u_loader (
        .pcie_clk          (pcie_clk),
        .pcie_reset_n      (pcie_reset_n),
        .dma_start         (dma_start),
        .dma_queue         (dma_queue),
        .dma_done          (dma_done),
        .new_tail          (new_tail),
        .host_update_mask  (host_update_mask),
        .host_update_queue (host_update_queue),
        .host_update_words (host_update_words),
        .f2c_queue_ready   (f2c_queue_ready),
        .f2c_head          (f2c_head),
        .f2c_tail          (f2c_tail),
        .f2c_kmem_addr     (f2c_kmem_addr),
        .tails_a           (tails_a),
        .heads_a           (heads_a),
        .l_addrs_a         (l_addrs_a),
        .h_addrs_a         (h_addrs_a)
    );

    qtable_bram q_table_tails (.pcie_clk(pcie_clk), .port_a(tails_a), .port_b(tails_b));
    qtable_bram q_table_heads (.pcie_clk(pcie_clk), .port_a(heads_a), .port_b(heads_b));
    qtable_bram q_table_l_addrs (.pcie_clk(pcie_clk), .port_a(l_addrs_a), .port_b(l_addrs_b));
    qtable_bram q_table_h_addrs (.pcie_clk(pcie_clk), .port_a(h_addrs_a), .port_b(h_addrs_b));
endmodule

`default_nettype wire

//--- source/qtable_bram.sv
`timescale 1ns/1ns
`default_nettype none
`include "qtable_config.svh"

module qtable_bram (
    input wire            pcie_clk,
    qtable_port_if.memory port_a,
    qtable_port_if.memory port_b
);
    import qtable_pkg::*;

    reg_word_t mem [`QT_NB_QUEUES];
    reg_word_t a_stage1;
    reg_word_t a_stage2;
    reg_word_t b_stage1;
    reg_word_t b_stage2;

    always_ff @(posedge pcie_clk) begin
        if (port_a.wr_en) begin
            mem[port_a.addr] <= port_a.wr_data;
        end
        if (port_b.wr_en) begin
            mem[port_b.addr] <= port_b.wr_data;
        end
    end

    // two output stages per port, old data on a same-cycle write
    always_ff @(posedge pcie_clk) begin
        if (port_a.rd_en) begin
            a_stage1 <= mem[port_a.addr];
        end
        if (port_b.rd_en) begin
            b_stage1 <= mem[port_b.addr];
        end
        a_stage2 <= a_stage1;
        b_stage2 <= b_stage1;
    end

    assign port_a.rd_data = a_stage2;
    assign port_b.rd_data = b_stage2;

    // loader and host side never write the same word together
    assert property (@(posedge pcie_clk)
        !(port_a.wr_en && port_b.wr_en && port_a.addr == port_b.addr))
        else $error("qtable_bram: write collision on both ports");
endmodule

`default_nettype wire

//--- source/qtable_config.svh
`ifndef QTABLE_CONFIG_SVH
`define QTABLE_CONFIG_SVH

// queue table geometry
`define QT_NB_QUEUES        4
`define QT_APP_IDX_WIDTH    2

// host register port
`define QT_PCIE_ADDR_WIDTH  16
// page index starts here in the host address
`define QT_PAGE_LSB         12
`define QT_REG_SIZE         4

// word positions within a queue page
`define QT_WORD_TAIL        0
`define QT_WORD_HEAD        1
`define QT_WORD_L_ADDR      2
`define QT_WORD_H_ADDR      3

// cpu to fpga registers, word 5 reads as zero
`define QT_WORD_C2F_TAIL    4
`define QT_WORD_C2F_KMEM_LO 6
`define QT_WORD_C2F_KMEM_HI 7

// cycles from rd_en to rd_data
`define QT_BRAM_READ_LATENCY 2

`endif

//--- source/qtable_pkg.sv
`default_nettype none
`include "qtable_config.svh"

package qtable_pkg;

    typedef logic [`QT_APP_IDX_WIDTH-1:0] queue_idx_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [63:0] kmem_addr_t;

    typedef logic [`QT_PCIE_ADDR_WIDTH-1:0] host_addr_t;
    typedef logic [511:0] host_data_t;
    typedef logic [63:0] host_be_t;

    // one bit or one word per table field
    typedef logic [3:0] field_mask_t;
    typedef logic [127:0] field_words_t;

    typedef enum logic [1:0] {
        TAILS,
        HEADS,
        L_ADDRS,
        H_ADDRS
    } table_field_t;

    typedef enum logic [2:0] {
        IDLE,
        BRAM_DELAY_1,
        BRAM_DELAY_2,
        SWITCH_QUEUE,
        WAIT_DMA
    } loader_state_t;

endpackage

`default_nettype wire

//--- source/qtable_port_if.sv
`timescale 1ns/1ns
`default_nettype none

// one port of a queue table memory
interface qtable_port_if;
    import qtable_pkg::*;

    queue_idx_t addr;
    reg_word_t  wr_data;
    logic       wr_en;
    logic       rd_en;
    // valid QT_BRAM_READ_LATENCY cycles after rd_en
    reg_word_t  rd_data;

    modport requester (
        output addr,
        output wr_data,
        output wr_en,
        output rd_en,
        input  rd_data
    );

    modport memory (
        input  addr,
        input  wr_data,
        input  wr_en,
        input  rd_en,
        output rd_data
    );
endinterface

`default_nettype wire

//--- source/queue_context_loader.sv
`timescale 1ns/1ns
`default_nettype none

module queue_context_loader (
    input  wire                          pcie_clk,
    input  wire                          pcie_reset_n,
    input  wire                          dma_start,
    input  wire qtable_pkg::queue_idx_t  dma_queue,
    input  wire                          dma_done,
    input  wire qtable_pkg::reg_word_t   new_tail,
    input  wire qtable_pkg::field_mask_t host_update_mask,
    input  wire qtable_pkg::queue_idx_t  host_update_queue,
    input  wire qtable_pkg::field_words_t host_update_words,
    output logic                         f2c_queue_ready,
    output qtable_pkg::reg_word_t        f2c_head,
    output qtable_pkg::reg_word_t        f2c_tail,
    output qtable_pkg::kmem_addr_t       f2c_kmem_addr,
    qtable_port_if.requester             tails_a,
    qtable_port_if.requester             heads_a,
    qtable_port_if.requester             l_addrs_a,
    qtable_port_if.requester             h_addrs_a
);
    import qtable_pkg::*;

    loader_state_t state;
    logic          queue_valid;
    queue_idx_t    active_queue;
    logic          rd_en_q;
    logic          tail_wr_en;
    // fields rewritten by the host since the memory read went out
    field_mask_t   fresh;
    field_mask_t   upd_hit;
    reg_word_t     upd_tail;
    reg_word_t     upd_head;
    reg_word_t     upd_lo;
    reg_word_t     upd_hi;

    assign upd_hit = (queue_valid && host_update_queue == active_queue) ?
        host_update_mask : '0;

    assign upd_tail = host_update_words[32*TAILS +: 32];
    assign upd_head = host_update_words[32*HEADS +: 32];
    assign upd_lo = host_update_words[32*L_ADDRS +: 32];
    assign upd_hi = host_update_words[32*H_ADDRS +: 32];

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            state <= IDLE;
            queue_valid <= 1'b0;
            fresh <= '0;
            rd_en_q <= 1'b0;
            tail_wr_en <= 1'b0;
            f2c_queue_ready <= 1'b0;
            f2c_head <= '0;
            f2c_tail <= '0;
            f2c_kmem_addr <= '0;
        end else begin
            rd_en_q <= 1'b0;
            tail_wr_en <= 1'b0;
            f2c_queue_ready <= 1'b0;
            fresh <= fresh | upd_hit;

            // live host updates of the active queue
            if (upd_hit[TAILS]) begin
                f2c_tail <= upd_tail;
            end
            if (upd_hit[HEADS]) begin
                f2c_head <= upd_head;
            end
            if (upd_hit[L_ADDRS]) begin
                f2c_kmem_addr[31:0] <= upd_lo;
            end
            if (upd_hit[H_ADDRS]) begin
                f2c_kmem_addr[63:32] <= upd_hi;
            end

            case (state)
                IDLE: begin
                    if (dma_start) begin
                        active_queue <= dma_queue;
                        queue_valid <= 1'b1;
                        rd_en_q <= 1'b1;
                        fresh <= '0;
                        state <= BRAM_DELAY_1;
                    end
                end
                BRAM_DELAY_1: begin
                    state <= BRAM_DELAY_2;
                end
                BRAM_DELAY_2: begin
                    state <= SWITCH_QUEUE;
                end
                SWITCH_QUEUE: begin
                    // stale memory data never overrides a newer host write
                    if (!(fresh[TAILS] || upd_hit[TAILS])) begin
                        f2c_tail <= tails_a.rd_data;
                    end
                    if (!(fresh[HEADS] || upd_hit[HEADS])) begin
                        f2c_head <= heads_a.rd_data;
                    end
                    if (!(fresh[L_ADDRS] || upd_hit[L_ADDRS])) begin
                        f2c_kmem_addr[31:0] <= l_addrs_a.rd_data;
                    end
                    if (!(fresh[H_ADDRS] || upd_hit[H_ADDRS])) begin
                        f2c_kmem_addr[63:32] <= h_addrs_a.rd_data;
                    end
                    f2c_queue_ready <= 1'b1;
                    state <= WAIT_DMA;
                end
                WAIT_DMA: begin
                    if (dma_done) begin
                        f2c_tail <= new_tail;
                        tail_wr_en <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign tails_a.addr = active_queue;
    assign heads_a.addr = active_queue;
    assign l_addrs_a.addr = active_queue;
    assign h_addrs_a.addr = active_queue;

    assign tails_a.rd_en = rd_en_q;
    assign heads_a.rd_en = rd_en_q;
    assign l_addrs_a.rd_en = rd_en_q;
    assign h_addrs_a.rd_en = rd_en_q;

    // write back the tail taken from new_tail one cycle earlier
    assign tails_a.wr_en = tail_wr_en;
    assign tails_a.wr_data = f2c_tail;
    assign heads_a.wr_en = 1'b0;
    assign heads_a.wr_data = '0;
    assign l_addrs_a.wr_en = 1'b0;
    assign l_addrs_a.wr_data = '0;
    assign h_addrs_a.wr_en = 1'b0;
    assign h_addrs_a.wr_data = '0;

    assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
        $rose(f2c_queue_ready) |-> $past(state) == SWITCH_QUEUE)
        else $error("queue_context_loader: ready raised outside SWITCH_QUEUE");
endmodule

`default_nettype wire
